// ==== source/fsync_pkg.sv ====
// shared widths, table and queue depths, and the port control state type of the sync core
package fsync_pkg;

  // a barrier id selects one entry of the directly mapped arrival table
  localparam int unsigned ID_WIDTH = 4;

  // one table entry per id, so the table covers the whole id space
  localparam int unsigned N_IDS = 16;

  // aggregation mask, one bit per tree level still to be climbed
  localparam int unsigned AGGR_WIDTH = 4;

  // RX ports of the node, even ones are horizontal and odd ones vertical
  localparam int unsigned N_RX_PORTS = 4;

  // children per channel, each channel sees two of the RX ports
  localparam int unsigned N_CHAN_PORTS = 2;

  // wake and error responses waiting for the local consumer of one channel
  localparam int unsigned LOCAL_FIFO_DEPTH = 4;

  // upward requests of both channels waiting for the parent node
  localparam int unsigned REMOTE_FIFO_DEPTH = 4;

  // each RX port runs a two-state FSM
  // a port in CTRL_CHECK has just been decided and takes no strobe this cycle
  typedef enum logic {
    CTRL_IDLE,
    CTRL_CHECK
  } ctrl_state_e;

endpackage

// ==== source/fsync_fifo.sv ====
// circular FIFO with occupancy count, full and empty flags and a misuse pulse
module fsync_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o,
  output logic             misuse_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));

  // there is no back-pressure, so a push into a full queue is dropped
  // and a pop on an empty queue does nothing, both are reported as misuse
  assign do_push  = push_i & ~full_o;
  assign do_pop   = pop_i & ~empty_o;
  assign misuse_o = (push_i & full_o) | (pop_i & empty_o);

  // the head entry is visible whenever the queue holds something
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the count unchanged
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // occupancy must stay within the storage over any push and pop sequence
  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CNT_W'(DEPTH))
    else $error("fifo count exceeds depth");

  // the pointers meet only when the queue is empty or completely full
  a_ptr_count_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_ptr_q == rd_ptr_q) == (empty_o || full_o))
    else $error("fifo pointers disagree with the occupancy count");

endmodule

// ==== source/fsync_barrier_rf.sv ====
// per-channel arrival table indexed by barrier id with two lookup and update ports
module fsync_barrier_rf
  import fsync_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [N_CHAN_PORTS-1:0]               check_i,
  input  logic [N_CHAN_PORTS-1:0][ID_WIDTH-1:0] id_i,
  output logic [N_CHAN_PORTS-1:0]               complete_o,
  output logic [N_CHAN_PORTS-1:0]               repeat_o
);

  // bit k of an entry records that child k has arrived at that barrier
  logic [N_CHAN_PORTS-1:0] arrived_q [N_IDS];
  logic [N_CHAN_PORTS-1:0] entry0;
  logic [N_CHAN_PORTS-1:0] entry1;
  logic                    same_id;

  assign entry0  = arrived_q[id_i[0]];
  assign entry1  = arrived_q[id_i[1]];
  assign same_id = check_i[0] & check_i[1] & (id_i[0] == id_i[1]);

  // a child that arrives twice before its partner is an id error
  assign repeat_o[0] = check_i[0] & entry0[0];
  assign repeat_o[1] = check_i[1] & entry1[1];

  // child 0 completes on a recorded partner or on a partner checking the
  // same id this cycle, the same-cycle case is reported on child 0 only
  assign complete_o[0] = check_i[0] & ~repeat_o[0] &
                         (entry0[1] | (same_id & ~repeat_o[1]));
  assign complete_o[1] = check_i[1] & ~repeat_o[1] & entry1[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int e = 0; e < N_IDS; e++) begin
        arrived_q[e] <= '0;
      end
    end else begin
      // record first arrivals
      for (int k = 0; k < N_CHAN_PORTS; k++) begin
        if (check_i[k] && !repeat_o[k] && !complete_o[k]) begin
          arrived_q[id_i[k]][k] <= 1'b1;
        end
      end
      // a completion frees its entry, which also swallows a same-cycle
      // arrival of the partner on that id
      for (int k = 0; k < N_CHAN_PORTS; k++) begin
        if (complete_o[k]) begin
          arrived_q[id_i[k]] <= '0;
        end
      end
    end
  end

endmodule

// ==== source/fsync_channel.sv ====
// channel engine with per-port control FSMs, the arrival table and the local response queue
module fsync_channel
  import fsync_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic [N_CHAN_PORTS-1:0]                 req_valid_i,
  input  logic [N_CHAN_PORTS-1:0][ID_WIDTH-1:0]   req_id_i,
  input  logic [N_CHAN_PORTS-1:0][AGGR_WIDTH-1:0] req_aggr_i,
  input  logic [N_CHAN_PORTS-1:0]                 req_root_i,
  input  logic                                    local_pop_i,
  output logic                                    up_valid_o,
  output logic [ID_WIDTH-1:0]                     up_id_o,
  output logic [AGGR_WIDTH-1:0]                   up_aggr_o,
  output logic                                    local_empty_o,
  output logic [N_CHAN_PORTS-1:0]                 local_dst_o,
  output logic                                    local_error_o,
  output logic                                    error_o
);

  ctrl_state_e             state_q [N_CHAN_PORTS];
  ctrl_state_e             state_d [N_CHAN_PORTS];
  logic [N_CHAN_PORTS-1:0] accept;
  logic [N_CHAN_PORTS-1:0] check;
  logic [N_CHAN_PORTS-1:0] sig_err;
  logic [N_CHAN_PORTS-1:0] complete;
  logic [N_CHAN_PORTS-1:0] repeat_err;
  logic [N_CHAN_PORTS-1:0] wake;
  logic [N_CHAN_PORTS-1:0] up_req;
  logic [N_CHAN_PORTS-1:0] rsp_valid;
  // a response entry is the destination mask followed by the error flag
  logic [N_CHAN_PORTS:0]   rsp_data [N_CHAN_PORTS];
  logic [N_CHAN_PORTS:0]   push_data;
  logic [N_CHAN_PORTS:0]   head_data;
  logic                    up_sel;
  logic                    lost;
  logic                    fifo_misuse;

  // a port takes a strobe in idle and spends the following cycle in check
  always_comb begin
    for (int i = 0; i < N_CHAN_PORTS; i++) begin
      accept[i] = 1'b0;
      unique case (state_q[i])
        CTRL_IDLE: begin
          accept[i]  = req_valid_i[i];
          state_d[i] = req_valid_i[i] ? CTRL_CHECK : CTRL_IDLE;
        end
        default: state_d[i] = CTRL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < N_CHAN_PORTS; i++) begin
        state_q[i] <= CTRL_IDLE;
      end
    end else begin
      state_q <= state_d;
    end
  end

  // an empty aggregation mask never reaches the table and is a signature error
  always_comb begin
    for (int i = 0; i < N_CHAN_PORTS; i++) begin
      check[i]     = accept[i] & (|req_aggr_i[i]);
      sig_err[i]   = accept[i] & ~(|req_aggr_i[i]);
      wake[i]      = complete[i] & req_root_i[i];
      up_req[i]    = complete[i] & ~req_root_i[i];
      rsp_valid[i] = sig_err[i] | repeat_err[i] | wake[i];
      // a wake goes to both children, an error only to the offending one
      rsp_data[i]  = wake[i] ? {{N_CHAN_PORTS{1'b1}}, 1'b0}
                             : {N_CHAN_PORTS'(1) << i, 1'b1};
    end
  end

  fsync_barrier_rf i_rf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .check_i    (check),
    .id_i       (req_id_i),
    .complete_o (complete),
    .repeat_o   (repeat_err)
  );

  // child 0 wins the single queue write, a second response is lost
  assign push_data = rsp_valid[0] ? rsp_data[0] : rsp_data[1];

  // upward completions go straight to the merger with one level consumed
  assign up_sel     = ~up_req[0];
  assign up_valid_o = |up_req;
  assign up_id_o    = req_id_i[up_sel];
  assign up_aggr_o  = req_aggr_i[up_sel] >> 1;

  assign lost    = (&rsp_valid) | (&up_req);
  assign error_o = lost | fifo_misuse;

  fsync_fifo #(
    .DEPTH (LOCAL_FIFO_DEPTH),
    .WIDTH (N_CHAN_PORTS + 1)
  ) i_local_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (|rsp_valid),
    .data_i   (push_data),
    .pop_i    (local_pop_i),
    .data_o   (head_data),
    .empty_o  (local_empty_o),
    .full_o   (),
    .misuse_o (fifo_misuse)
  );

  assign local_dst_o   = head_data[N_CHAN_PORTS:1];
  assign local_error_o = head_data[0];

  // the sender must leave one idle cycle after every strobe on a port
  for (genvar i = 0; i < N_CHAN_PORTS; i++) begin : gen_strobe_guard
    a_no_strobe_in_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
      state_q[i] == CTRL_CHECK |-> !req_valid_i[i])
      else $error("strobe on port %0d while in check", i);
  end

endmodule

// ==== source/fsync_remote_merge.sv ====
// merger of both channels' upward requests into one remote queue through a holding slot
module fsync_remote_merge
  import fsync_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  h_valid_i,
  input  logic [ID_WIDTH-1:0]   h_id_i,
  input  logic [AGGR_WIDTH-1:0] h_aggr_i,
  input  logic                  v_valid_i,
  input  logic [ID_WIDTH-1:0]   v_id_i,
  input  logic [AGGR_WIDTH-1:0] v_aggr_i,
  input  logic                  remote_pop_i,
  output logic                  remote_empty_o,
  output logic [ID_WIDTH-1:0]   remote_id_o,
  output logic [AGGR_WIDTH-1:0] remote_aggr_o,
  output logic                  remote_src_o,
  output logic                  error_o
);

  logic                           slot_valid_q;
  logic [ID_WIDTH-1:0]            slot_id_q;
  logic [AGGR_WIDTH-1:0]          slot_aggr_q;
  logic                           slot_load;
  logic                           slot_drain;
  logic                           v_drop;
  logic                           push;
  logic [ID_WIDTH+AGGR_WIDTH:0]   push_data;
  logic [ID_WIDTH+AGGR_WIDTH:0]   head_data;
  logic                           fifo_misuse;

  // a vertical request colliding with a horizontal one is parked,
  // one arriving while the slot is busy has nowhere to go
  assign slot_load  = v_valid_i & h_valid_i & ~slot_valid_q;
  assign slot_drain = slot_valid_q & ~h_valid_i;
  assign v_drop     = v_valid_i & slot_valid_q;

  // queue entry is source flag, id and aggregation mask, horizontal first,
  // then the parked vertical request, then a fresh vertical one
  assign push = h_valid_i | slot_valid_q | v_valid_i;
  always_comb begin
    if (h_valid_i) begin
      push_data = {1'b0, h_id_i, h_aggr_i};
    end else if (slot_valid_q) begin
      push_data = {1'b1, slot_id_q, slot_aggr_q};
    end else begin
      push_data = {1'b1, v_id_i, v_aggr_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= 1'b0;
    end else if (slot_load) begin
      slot_valid_q <= 1'b1;
    end else if (slot_drain) begin
      slot_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (slot_load) begin
      slot_id_q   <= v_id_i;
      slot_aggr_q <= v_aggr_i;
    end
  end

  fsync_fifo #(
    .DEPTH (REMOTE_FIFO_DEPTH),
    .WIDTH (ID_WIDTH + AGGR_WIDTH + 1)
  ) i_remote_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push_i   (push),
    .data_i   (push_data),
    .pop_i    (remote_pop_i),
    .data_o   (head_data),
    .empty_o  (remote_empty_o),
    .full_o   (),
    .misuse_o (fifo_misuse)
  );

  assign {remote_src_o, remote_id_o, remote_aggr_o} = head_data;
  assign error_o = v_drop | fifo_misuse;

  // a vertical request meeting a horizontal one is either parked with its own
  // fields for the next cycle or reported as dropped
  a_slot_park: assert property (@(posedge clk_i) disable iff (!rst_ni)
    v_valid_i && h_valid_i |=> $past(error_o) ||
      (slot_valid_q && {slot_id_q, slot_aggr_q} == $past({v_id_i, v_aggr_i})))
    else $error("colliding vertical request neither parked nor reported");

endmodule

// ==== source/fsync_cc_top.sv ====
// sync control core top with RX port split per channel, two engines and the remote merger
module fsync_cc_top
  import fsync_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [N_RX_PORTS-1:0]                 req_valid_i,
  input  logic [N_RX_PORTS-1:0][ID_WIDTH-1:0]   req_id_i,
  input  logic [N_RX_PORTS-1:0][AGGR_WIDTH-1:0] req_aggr_i,
  input  logic [N_RX_PORTS-1:0]                 req_root_i,
  input  logic [1:0]                            local_pop_i,
  input  logic                                  remote_pop_i,
  output logic [1:0]                            local_empty_o,
  output logic [1:0][N_CHAN_PORTS-1:0]          local_dst_o,
  output logic [1:0]                            local_error_o,
  output logic                                  remote_empty_o,
  output logic [ID_WIDTH-1:0]                   remote_id_o,
  output logic [AGGR_WIDTH-1:0]                 remote_aggr_o,
  output logic                                  remote_src_o,
  output logic [2:0]                            detected_error_o
);

  // channel index 0 is horizontal and 1 is vertical
  logic [1:0][N_CHAN_PORTS-1:0]                 ch_valid;
  logic [1:0][N_CHAN_PORTS-1:0][ID_WIDTH-1:0]   ch_id;
  logic [1:0][N_CHAN_PORTS-1:0][AGGR_WIDTH-1:0] ch_aggr;
  logic [1:0][N_CHAN_PORTS-1:0]                 ch_root;
  logic [1:0]                                   up_valid;
  logic [1:0][ID_WIDTH-1:0]                     up_id;
  logic [1:0][AGGR_WIDTH-1:0]                   up_aggr;

  // RX port 2k+c is child k of channel c
  for (genvar c = 0; c < 2; c++) begin : gen_split
    for (genvar k = 0; k < N_CHAN_PORTS; k++) begin : gen_child
      assign ch_valid[c][k] = req_valid_i[2*k+c];
      assign ch_id[c][k]    = req_id_i[2*k+c];
      assign ch_aggr[c][k]  = req_aggr_i[2*k+c];
      assign ch_root[c][k]  = req_root_i[2*k+c];
    end
  end

  fsync_channel i_h_channel (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (ch_valid[0]),
    .req_id_i      (ch_id[0]),
    .req_aggr_i    (ch_aggr[0]),
    .req_root_i    (ch_root[0]),
    .local_pop_i   (local_pop_i[0]),
    .up_valid_o    (up_valid[0]),
    .up_id_o       (up_id[0]),
    .up_aggr_o     (up_aggr[0]),
    .local_empty_o (local_empty_o[0]),
    .local_dst_o   (local_dst_o[0]),
    .local_error_o (local_error_o[0]),
    .error_o       (detected_error_o[0])
  );

  fsync_channel i_v_channel (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (ch_valid[1]),
    .req_id_i      (ch_id[1]),
    .req_aggr_i    (ch_aggr[1]),
    .req_root_i    (ch_root[1]),
    .local_pop_i   (local_pop_i[1]),
    .up_valid_o    (up_valid[1]),
    .up_id_o       (up_id[1]),
    .up_aggr_o     (up_aggr[1]),
    .local_empty_o (local_empty_o[1]),
    .local_dst_o   (local_dst_o[1]),
    .local_error_o (local_error_o[1]),
    .error_o       (detected_error_o[1])
  );

  // horizontal completions take priority for the shared remote queue
  fsync_remote_merge i_remote_merge (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .h_valid_i      (up_valid[0]),
    .h_id_i         (up_id[0]),
    .h_aggr_i       (up_aggr[0]),
    .v_valid_i      (up_valid[1]),
    .v_id_i         (up_id[1]),
    .v_aggr_i       (up_aggr[1]),
    .remote_pop_i   (remote_pop_i),
    .remote_empty_o (remote_empty_o),
    .remote_id_o    (remote_id_o),
    .remote_aggr_o  (remote_aggr_o),
    .remote_src_o   (remote_src_o),
    .error_o        (detected_error_o[2])
  );

endmodule

// ==== verification/tb_fsync_cc.sv ====
// testbench for the sync control core that replays the golden command file against the DUT
module tb_fsync_cc
  import fsync_pkg::*;
();

  localparam int unsigned RESET_CYCLES = 16;

  // command codes of the golden file, first column of every line
  typedef enum logic [3:0] {
    CMD_REQUEST   = 4'h0,
    CMD_WAIT      = 4'h1,
    CMD_LOCAL     = 4'h2,
    CMD_REMOTE    = 4'h3,
    CMD_POP_EMPTY = 4'h4,
    CMD_ERRORS    = 4'h5,
    CMD_END       = 4'h7
  } cmd_e;

  // one golden line, the meaning of a to d depends on the code
  typedef struct packed {
    logic [3:0] code;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] d;
  } cmd_t;

  logic                                  clk = 1'b0;
  logic                                  rst_n;
  logic [N_RX_PORTS-1:0]                 req_valid;
  logic [N_RX_PORTS-1:0][ID_WIDTH-1:0]   req_id;
  logic [N_RX_PORTS-1:0][AGGR_WIDTH-1:0] req_aggr;
  logic [N_RX_PORTS-1:0]                 req_root;
  logic [1:0]                            local_pop;
  logic                                  remote_pop;
  logic [1:0]                            local_empty;
  logic [1:0][N_CHAN_PORTS-1:0]          local_dst;
  logic [1:0]                            local_error;
  logic                                  remote_empty;
  logic [ID_WIDTH-1:0]                   remote_id;
  logic [AGGR_WIDTH-1:0]                 remote_aggr;
  logic                                  remote_src;
  logic [2:0]                            detected_error;
  // error pulses collected since the last error check
  logic [2:0]                            err_seen;

  cmd_t cmds [$];
  int   cycle_count  = 0;
  int   cycle_limit  = 0;
  int   value_errors = 0;
  int   other_errors = 0;

  always #2 clk = ~clk;

  fsync_cc_top i_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .req_valid_i      (req_valid),
    .req_id_i         (req_id),
    .req_aggr_i       (req_aggr),
    .req_root_i       (req_root),
    .local_pop_i      (local_pop),
    .remote_pop_i     (remote_pop),
    .local_empty_o    (local_empty),
    .local_dst_o      (local_dst),
    .local_error_o    (local_error),
    .remote_empty_o   (remote_empty),
    .remote_id_o      (remote_id),
    .remote_aggr_o    (remote_aggr),
    .remote_src_o     (remote_src),
    .detected_error_o (detected_error)
  );

  // the limit is set once the golden file is loaded, so it scales with the test length
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles while waiting for the DUT", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  // one clock cycle starting at a falling edge, error outputs follow the inputs
  // driven there and are taken between that edge and the next rising edge,
  // the single-cycle strobes drop again at the following falling edge
  task automatic step();
    #1;
    err_seen = err_seen | detected_error;
    @(negedge clk);
    req_valid  = '0;
    local_pop  = '0;
    remote_pop = '0;
  endtask

  task automatic load_commands();
    int               fd;
    int               got;
    bit               done;
    logic [8*128-1:0] header_line;
    cmd_t             entry;
    logic [3:0]       code;
    logic [7:0]       a;
    logic [7:0]       b;
    logic [7:0]       c;
    logic [7:0]       d;
    fd = $fopen("verification/fsync_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open the golden file verification/fsync_golden.txt");
      other_errors++;
      return;
    end
    // the first two lines describe the columns
    got  = $fgets(header_line, fd);
    got  = $fgets(header_line, fd);
    done = 1'b0;
    while (!done) begin
      got = $fscanf(fd, "%h %h %h %h %h", code, a, b, c, d);
      if (got != 5) begin
        done = 1'b1;
      end else begin
        entry.code = code;
        entry.a    = a;
        entry.b    = b;
        entry.c    = c;
        entry.d    = d;
        cmds.push_back(entry);
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_request(input logic [1:0] port, input logic [ID_WIDTH-1:0] id,
                               input logic [AGGR_WIDTH-1:0] aggr, input logic root);
    req_valid[port] = 1'b1;
    req_id[port]    = id;
    req_aggr[port]  = aggr;
    req_root[port]  = root;
  endtask

  // queue 2 is the remote queue, 0 and 1 are the local queues
  task automatic pop_queue(input logic [1:0] queue);
    if (queue == 2'd2) begin
      remote_pop = 1'b1;
    end else begin
      local_pop[queue[0]] = 1'b1;
    end
    step();
  endtask

  task automatic check_local(input logic ch, input logic [N_CHAN_PORTS-1:0] dst_exp,
                             input logic err_exp);
    if (local_dst[ch] !== dst_exp || local_error[ch] !== err_exp) begin
      $display("FAILED at time %0t, local queue %0d head dst %b err %b, expected dst %b err %b",
               $time, ch, local_dst[ch], local_error[ch], dst_exp, err_exp);
      value_errors++;
    end
  endtask

  task automatic check_remote(input logic [ID_WIDTH-1:0] id_exp,
                              input logic [AGGR_WIDTH-1:0] aggr_exp, input logic src_exp);
    if (remote_id !== id_exp || remote_aggr !== aggr_exp || remote_src !== src_exp) begin
      $display("FAILED at time %0t, remote head id %h aggr %b src %b, expected %h %b %b",
               $time, remote_id, remote_aggr, remote_src, id_exp, aggr_exp, src_exp);
      value_errors++;
    end
  endtask

  task automatic check_error(input logic [2:0] exp);
    if (err_seen !== exp) begin
      $display("FAILED at time %0t, detected errors %b, expected %b", $time, err_seen, exp);
      value_errors++;
    end
    err_seen = '0;
  endtask

  // a head is compared once the queue holds an entry, then it is popped
  task automatic expect_local(input logic ch, input logic [N_CHAN_PORTS-1:0] dst_exp,
                              input logic err_exp);
    while (local_empty[ch]) begin
      step();
    end
    check_local(ch, dst_exp, err_exp);
    pop_queue({1'b0, ch});
  endtask

  task automatic expect_remote(input logic [ID_WIDTH-1:0] id_exp,
                               input logic [AGGR_WIDTH-1:0] aggr_exp, input logic src_exp);
    while (remote_empty) begin
      step();
    end
    check_remote(id_exp, aggr_exp, src_exp);
    pop_queue(2'd2);
  endtask

  initial begin
    int   idx;
    bit   finished;
    cmd_t cmd;
    req_valid  = '0;
    req_id     = '0;
    req_aggr   = '0;
    req_root   = '0;
    local_pop  = '0;
    remote_pop = 1'b0;
    rst_n      = 1'b0;
    err_seen   = '0;
    load_commands();
    cycle_limit = cmds.size() * 10 + 100;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    step();
    step();
    idx      = 0;
    finished = 1'b0;
    while (!finished && idx < cmds.size()) begin
      cmd = cmds[idx];
      case (cmd.code)
        CMD_REQUEST: drive_request(cmd.a[1:0], cmd.b[ID_WIDTH-1:0], cmd.c[AGGR_WIDTH-1:0],
                                   cmd.d[0]);
        CMD_WAIT: repeat (int'(cmd.a)) step();
        CMD_LOCAL: expect_local(cmd.a[0], cmd.b[N_CHAN_PORTS-1:0], cmd.c[0]);
        CMD_REMOTE: expect_remote(cmd.a[ID_WIDTH-1:0], cmd.b[AGGR_WIDTH-1:0], cmd.c[0]);
        CMD_POP_EMPTY: begin
          pop_queue(cmd.a[1:0]);
          check_error(cmd.b[2:0]);
        end
        CMD_ERRORS: check_error(cmd.a[2:0]);
        CMD_END: finished = 1'b1;
        default: begin
          $display("unknown command code %h in golden command %0d", cmd.code, idx);
          other_errors++;
        end
      endcase
      idx++;
    end
    if (!finished) begin
      $display("the golden file ended without an end command");
      other_errors++;
    end
    // every response has been consumed and no error pulse is left over
    if (local_empty !== 2'b11 || remote_empty !== 1'b1) begin
      $display("queues still hold entries at the end of the run");
      other_errors++;
    end
    check_error(3'b000);
    $display("value mismatches %0d, other errors %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== verification/fsync_golden.txt ====
# columns cmd a b c d in hex, 0 request port id aggr root, 1 wait cycles, 7 end
# 2 local chan dst err, 3 remote id aggr src, 4 pop queue errmask, 5 errors mask
0 0 3 1 1
1 2 0 0 0
0 2 3 1 1
2 0 3 0 0
0 1 5 6 0
1 2 0 0 0
0 3 5 6 0
3 5 3 1 0
0 0 7 1 0
1 2 0 0 0
0 0 7 1 0
2 0 1 1 0
0 2 7 0 0
2 0 2 1 0
0 2 7 1 1
2 0 3 0 0
0 0 9 4 0
0 1 a 8 0
1 2 0 0 0
0 2 9 4 0
0 3 a 8 0
3 9 2 0 0
3 a 4 1 0
4 1 2 0 0
0 0 1 2 0
0 2 1 2 0
1 2 0 0 0
0 0 2 2 0
0 2 2 2 0
1 2 0 0 0
0 0 3 2 0
0 2 3 2 0
1 2 0 0 0
0 0 4 2 0
0 2 4 2 0
1 2 0 0 0
0 0 5 2 0
0 2 5 2 0
1 2 0 0 0
5 4 0 0 0
3 1 1 0 0
3 2 1 0 0
3 3 1 0 0
3 4 1 0 0
4 2 4 0 0
7 0 0 0 0

// ==== verilog.f ====
source/fsync_pkg.sv
source/fsync_fifo.sv
source/fsync_barrier_rf.sv
source/fsync_channel.sv
source/fsync_remote_merge.sv
source/fsync_cc_top.sv
verification/tb_fsync_cc.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_fsync_cc \
		-f verilog.f --Mdir obj_dir -o sim_fsync_cc

run: build
	./obj_dir/sim_fsync_cc | tee sim.log
	@if grep -q "Regression failed" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@grep -q "Regression passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module fsync_cc_top -f verilog.f

clean:
	rm -rf obj_dir sim.log
